// ==== Makefile ====
VERILATOR ?= verilator
TOP       := sc_datapath_tb
FILELIST  := sc_core.f
FLAGS     := --timing --assert
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := PASS: all tests

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/sc_datapath_tb.sv ====
// testbench for sc_datapath: clock, reset, instruction memory, isa reference model, checks
`include "sc_core_cfg.svh"

module sc_datapath_tb import isa_pkg::*, datapath_pkg::*;;

    localparam int MEM_WORDS    = 64;
    localparam int MAX_EXP      = 64;
    localparam int MODEL_STEPS  = 200;
    localparam int HALT_TIMEOUT = 2000;
    localparam int QUIET_CYCLES = 8;

    logic     CLK;
    logic     nrst = 1'b0;
    logic     ihit = 1'b0;
    word_t    imemload = '0;
    logic     imemREN;
    pc_t      imemaddr;
    logic     halt;
    logic     retire_wen;
    reg_sel_t retire_sel;
    word_t    retire_wdat;

    integer   seed = 32'he36c;
    logic     rand_ihit = 1'b0;
    word_t    prog [MEM_WORDS];
    reg_sel_t exp_sel [MAX_EXP];
    word_t    exp_dat [MAX_EXP];
    int       exp_count = 0;
    logic     exp_halt = 1'b0;
    int       ret_ptr;
    reg_sel_t exp_sel_now;
    word_t    exp_dat_now;
    int       check_errs = 0;
    int       run_errs = 0;

    sc_datapath dut (
        .CLK         (CLK),
        .nrst        (nrst),
        .ihit        (ihit),
        .imemload    (imemload),
        .imemREN     (imemREN),
        .imemaddr    (imemaddr),
        .halt        (halt),
        .retire_wen  (retire_wen),
        .retire_sel  (retire_sel),
        .retire_wdat (retire_wdat)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    function automatic word_t enc(opcode_t op, int rd, int rs1, int rs2, int imm);
        enc = {op, rd[3:0], rs1[3:0], rs2[3:0], imm[15:0]};
    endfunction

    // harmless nop whose immediate folds in the whole address
    function automatic word_t fill_word(pc_t addr);
        fill_word = {OP_NOP, 12'h000, addr[15:0] ^ addr[31:16]};
    endfunction

    function automatic word_t mem_word(pc_t addr);
        if (addr[31:8] == '0) begin
            mem_word = prog[addr[7:2]];
        end else begin
            mem_word = fill_word(addr);
        end
    endfunction

    task automatic load_program();
        for (int i = 0; i < MEM_WORDS; i++) begin
            prog[i] = fill_word(pc_t'(i) << 2);
        end
        prog[0]  = enc(OP_ADDI, 1, 0, 0, 5);
        prog[1]  = enc(OP_ADDI, 2, 0, 0, 3);
        // dependent chain, each one waits on the previous write
        prog[2]  = enc(OP_ADD,  3, 1, 2, 0);
        prog[3]  = enc(OP_SUB,  4, 3, 1, 0);
        prog[4]  = enc(OP_AND,  5, 3, 4, 0);
        prog[5]  = enc(OP_OR,   6, 3, 4, 0);
        prog[6]  = enc(OP_XOR,  7, 6, 1, 0);
        // taken beq skips two words
        prog[7]  = enc(OP_BEQ,  13, 4, 2, 3);
        prog[8]  = enc(OP_ADDI, 8, 0, 0, 99);
        prog[9]  = enc(OP_ADDI, 8, 0, 0, 98);
        prog[10] = enc(OP_JAL,  9, 0, 0, 3);
        prog[11] = enc(OP_ADDI, 10, 0, 0, 77);
        prog[12] = enc(OP_ADDI, 10, 0, 0, 76);
        // not taken, falls through
        prog[13] = enc(OP_BEQ,  14, 1, 2, 2);
        prog[14] = enc(OP_ADDI, 11, 7, 0, -20);
        prog[15] = enc(OP_ADD,  0, 1, 1, 0);
        prog[16] = enc(OP_ADDI, 12, 11, 0, 1);
        prog[17] = enc(OP_HALT, 0, 0, 0, 0);
        // behind halt, never retires
        prog[18] = enc(OP_ADDI, 15, 0, 0, 55);
    endtask

    // isa level model, one instruction per step
    task automatic build_expected();
        word_t   regs [`NREGS];
        pc_t     pc;
        pc_t     next_pc;
        word_t   instr;
        word_t   sext;
        word_t   a;
        word_t   b;
        word_t   res;
        opcode_t op;
        logic    wr;
        int      steps;
        for (int i = 0; i < `NREGS; i++) begin
            regs[i] = '0;
        end
        pc = `PC_RESET;
        steps = 0;
        exp_count = 0;
        exp_halt = 1'b0;
        while (!exp_halt && steps < MODEL_STEPS) begin
            instr = mem_word(pc);
            op = opcode_t'(instr[31:28]);
            sext = {{16{instr[15]}}, instr[15:0]};
            a = regs[instr[23:20]];
            b = regs[instr[19:16]];
            res = '0;
            wr = 1'b1;
            next_pc = pc + 32'd4;
            case (op)
                OP_ADD:  res = a + b;
                OP_SUB:  res = a - b;
                OP_AND:  res = a & b;
                OP_OR:   res = a | b;
                OP_XOR:  res = a ^ b;
                OP_ADDI: res = a + sext;
                OP_JAL: begin
                    res = pc + 32'd4;
                    next_pc = pc + (sext << 2);
                end
                OP_BEQ: begin
                    wr = 1'b0;
                    if (a == b) begin
                        next_pc = pc + (sext << 2);
                    end
                end
                OP_HALT: begin
                    wr = 1'b0;
                    exp_halt = 1'b1;
                end
                default: wr = 1'b0;
            endcase
            if (wr && instr[27:24] != 4'h0 && exp_count < MAX_EXP) begin
                regs[instr[27:24]] = res;
                exp_sel[exp_count[5:0]] = instr[27:24];
                exp_dat[exp_count[5:0]] = res;
                exp_count++;
            end
            pc = next_pc;
            steps++;
        end
    endtask

    // memory answers the held address, ihit random or tied high
    always @(negedge CLK) begin
        if (rand_ihit) begin
            ihit <= ($random(seed) & 3) != 0;
        end else begin
            ihit <= 1'b1;
        end
        imemload <= mem_word(imemaddr);
    end

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            ret_ptr <= 0;
        end else if (retire_wen) begin
            ret_ptr <= ret_ptr + 1;
        end
    end

    always_comb begin
        exp_sel_now = '0;
        exp_dat_now = '0;
        if (ret_ptr < exp_count) begin
            exp_sel_now = exp_sel[ret_ptr[5:0]];
            exp_dat_now = exp_dat[ret_ptr[5:0]];
        end
    end

    a_reset_addr: assert property (@(posedge CLK) $rose(nrst) |-> imemaddr == `PC_RESET)
        else begin
            check_errs++;
            $display("ERR imemaddr got %h exp %h", $sampled(imemaddr), `PC_RESET);
        end

    a_reset_flags: assert property (@(posedge CLK) $rose(nrst) |-> imemREN && !halt && !retire_wen)
        else begin
            check_errs++;
            $display("ERR imemREN/halt/retire_wen got %h/%h/%h exp 1/0/0",
                     $sampled(imemREN), $sampled(halt), $sampled(retire_wen));
        end

    a_retire_left: assert property (
        @(posedge CLK) disable iff (!nrst)
        retire_wen |-> ret_ptr < exp_count
    ) else begin
        check_errs++;
        $display("retire_wen seen after all %0d expected writes had retired", exp_count);
    end

    a_retire_sel: assert property (
        @(posedge CLK) disable iff (!nrst)
        retire_wen && ret_ptr < exp_count |-> retire_sel == exp_sel_now
    ) else begin
        check_errs++;
        $display("ERR retire_sel got %h exp %h", $sampled(retire_sel), $sampled(exp_sel_now));
    end

    a_retire_wdat: assert property (
        @(posedge CLK) disable iff (!nrst)
        retire_wen && ret_ptr < exp_count |-> retire_wdat == exp_dat_now
    ) else begin
        check_errs++;
        $display("ERR retire_wdat got %h exp %h", $sampled(retire_wdat), $sampled(exp_dat_now));
    end

    a_halt_fetch: assert property (@(posedge CLK) disable iff (!nrst) halt |-> !imemREN)
        else begin
            check_errs++;
            $display("ERR imemREN got %h exp 0", $sampled(imemREN));
        end

    a_halt_quiet: assert property (@(posedge CLK) disable iff (!nrst) halt |-> !retire_wen)
        else begin
            check_errs++;
            $display("ERR retire_wen got %h exp 0", $sampled(retire_wen));
        end

    a_halt_complete: assert property (
        @(posedge CLK) disable iff (!nrst)
        $rose(halt) |-> ret_ptr == exp_count
    ) else begin
        check_errs++;
        $display("halt rose with %0d of %0d expected writes retired", $sampled(ret_ptr), exp_count);
    end

    task automatic run_program(input logic random_hit);
        int cycles;
        @(negedge CLK);
        rand_ihit = random_hit;
        nrst = 1'b0;
        repeat (10) @(negedge CLK);
        nrst = 1'b1;
        cycles = 0;
        while (!halt && cycles < HALT_TIMEOUT) begin
            @(negedge CLK);
            cycles++;
        end
        if (!halt) begin
            run_errs++;
            $display("timeout: halt did not rise within %0d cycles", HALT_TIMEOUT);
        end
        // watch for stray retirements after halt
        repeat (QUIET_CYCLES) @(negedge CLK);
    endtask

    initial begin
        load_program();
        build_expected();
        if (!exp_halt) begin
            run_errs++;
            $display("reference model did not reach HALT within %0d steps", MODEL_STEPS);
        end
        run_program(1'b1);
        run_program(1'b0);
        $display("errors: assertion failures %0d, run failures %0d", check_errs, run_errs);
        if (check_errs == 0 && run_errs == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== sc_core.f ====
+incdir+src
src/isa_pkg.sv
src/datapath_pkg.sv
src/fetch_stage.sv
src/scoreboard.sv
src/execute.sv
src/writeback.sv
src/sc_datapath.sv
dv/sc_datapath_tb.sv

// ==== src/datapath_pkg.sv ====
// datapath types: data word, program counter, scoreboard state enum
`include "sc_core_cfg.svh"

package datapath_pkg;

    // register and instruction data
    typedef logic [`WORD_W-1:0] word_t;

    // byte address, always word aligned
    typedef logic [`WORD_W-1:0] pc_t;

    // issue is locked for good once halt has issued
    typedef enum logic {
        SB_RUN,
        SB_HALTED
    } sb_state_t;

endpackage

// ==== src/execute.sv ====
// execute stage: alu, beq compare, jal link, branch target and misprediction redirect
`include "sc_core_cfg.svh"

module execute import isa_pkg::*, datapath_pkg::*; (
    input  logic     iss_valid,
    input  opcode_t  iss_op,
    input  alu_op_t  iss_alu_op,
    input  reg_sel_t iss_rd,
    input  word_t    iss_rdat1,
    input  word_t    iss_rdat2,
    input  imm_t     iss_imm,
    input  pc_t      iss_pc,
    output logic     miss,
    output pc_t      correct_pc,
    output logic     ex_done,
    output logic     ex_wen,
    output reg_sel_t ex_sel,
    output word_t    ex_wdat,
    output logic     ex_halt
);

    word_t imm_ext;
    word_t opnd_b;
    word_t alu_res;
    pc_t   link;
    logic  taken;

    assign imm_ext = {{(`WORD_W - $bits(imm_t)){iss_imm[$bits(imm_t)-1]}}, iss_imm};

    // addi takes the immediate as operand b
    assign opnd_b = (iss_op == OP_ADDI) ? imm_ext : iss_rdat2;

    always_comb begin
        case (iss_alu_op)
            ALU_SUB: alu_res = iss_rdat1 - opnd_b;
            ALU_AND: alu_res = iss_rdat1 & opnd_b;
            ALU_OR:  alu_res = iss_rdat1 | opnd_b;
            ALU_XOR: alu_res = iss_rdat1 ^ opnd_b;
            default: alu_res = iss_rdat1 + opnd_b;
        endcase
    end

    // fetch always ran ahead on pc + 4, so every taken transfer is a miss
    assign link       = iss_pc + 32'd4;
    assign correct_pc = iss_pc + (imm_ext << 2);
    assign taken      = (iss_op == OP_JAL)
                     || ((iss_op == OP_BEQ) && (iss_rdat1 == iss_rdat2));
    assign miss       = iss_valid && taken;

    assign ex_done = iss_valid;
    assign ex_wen  = iss_valid
                  && (iss_op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI, OP_JAL});
    assign ex_sel  = iss_rd;
    assign ex_wdat = (iss_op == OP_JAL) ? link : alu_res;
    assign ex_halt = iss_valid && (iss_op == OP_HALT);

    // a redirect lands on a word boundary
    always_comb begin
        a_miss_aligned: assert (!miss || (correct_pc[1:0] == 2'b00))
            else $error("execute: redirect target not word aligned");
    end

endmodule

// ==== src/fetch_stage.sv ====
// fetch stage: program counter, instruction port request, misprediction redirect
`include "sc_core_cfg.svh"

module fetch_stage import datapath_pkg::*; (
    input  logic  CLK,
    input  logic  nrst,
    input  logic  ihit,
    input  word_t imemload,
    input  logic  freeze,
    input  logic  miss,
    input  pc_t   correct_pc,
    input  logic  halt,
    output logic  imemREN,
    output pc_t   imemaddr,
    output logic  f_valid,
    output word_t f_instr,
    output pc_t   f_pc
);

    pc_t pc;

    // redirect wins over a frozen or pending request
    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            pc <= `PC_RESET;
        end else if (miss) begin
            pc <= correct_pc;
        end else if (ihit && imemREN && !freeze) begin
            pc <= pc + 32'd4;
        end
    end

    // request stays up until the core halts
    assign imemREN  = !halt;
    assign imemaddr = pc;

    // word fetched under a miss is on the wrong path
    assign f_valid = ihit && imemREN && !miss;
    assign f_instr = imemload;
    assign f_pc    = pc;

    // a frozen request must not move
    a_frozen_addr_stable: assert property (
        @(posedge CLK) disable iff (!nrst)
        freeze |=> $stable(imemaddr)
    ) else $error("fetch: imemaddr changed while frozen");

endmodule

// ==== src/isa_pkg.sv ====
// instruction set types: opcode enum, register selector, immediate, alu operation enum
`include "sc_core_cfg.svh"

package isa_pkg;

    // instruction word layout
    // [31:28] opcode, [27:24] rd, [23:20] rs1, [19:16] rs2, [15:0] immediate
    // branch and jump targets are pc + imm * 4, jal links pc + 4 into rd
    localparam int OPC_LSB = 28;
    localparam int RD_LSB  = 24;
    localparam int RS1_LSB = 20;
    localparam int RS2_LSB = 16;

    typedef enum logic [3:0] {
        OP_NOP  = 4'h0,
        OP_ADD  = 4'h1,
        OP_SUB  = 4'h2,
        OP_AND  = 4'h3,
        OP_OR   = 4'h4,
        OP_XOR  = 4'h5,
        OP_ADDI = 4'h6,
        OP_BEQ  = 4'h7,
        OP_JAL  = 4'h8,
        OP_HALT = 4'hf
    } opcode_t;

    typedef logic [`REG_SEL_W-1:0] reg_sel_t;

    // sign extended where it is used
    typedef logic signed [15:0] imm_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_t;

endpackage

// ==== src/sc_core_cfg.svh ====
// core configuration macros: word width, register count, selector width, reset pc
`ifndef SC_CORE_CFG_SVH
`define SC_CORE_CFG_SVH

// data and instruction word width
`define WORD_W 32

// architectural register file
`define NREGS 16

// must cover NREGS
`define REG_SEL_W 4

// first fetch address out of reset
`define PC_RESET 32'h0000_0000

`endif

// ==== src/sc_datapath.sv ====
// datapath top: fetch latch, execute to writeback latch, retire register, stage instances
module sc_datapath import isa_pkg::*, datapath_pkg::*; (
    input  logic     CLK,
    input  logic     nrst,
    input  logic     ihit,
    input  word_t    imemload,
    output logic     imemREN,
    output pc_t      imemaddr,
    output logic     halt,
    output logic     retire_wen,
    output reg_sel_t retire_sel,
    output word_t    retire_wdat
);

    logic     f_valid;
    word_t    f_instr;
    pc_t      f_pc;
    logic     sb_valid;
    word_t    sb_instr;
    pc_t      sb_pc;
    logic     freeze;
    logic     iss_valid;
    opcode_t  iss_op;
    alu_op_t  iss_alu_op;
    reg_sel_t iss_rd;
    word_t    iss_rdat1;
    word_t    iss_rdat2;
    imm_t     iss_imm;
    pc_t      iss_pc;
    logic     miss;
    pc_t      correct_pc;
    logic     ex_done;
    logic     ex_wen;
    reg_sel_t ex_sel;
    word_t    ex_wdat;
    logic     ex_halt;
    logic     wb_in_done;
    logic     wb_in_wen;
    reg_sel_t wb_in_sel;
    word_t    wb_in_wdat;
    logic     wb_in_halt;
    logic     wb_wen;
    reg_sel_t wb_sel;
    word_t    wb_wdat;
    logic     wb_halt;

    fetch_stage u_fetch (
        .CLK        (CLK),
        .nrst       (nrst),
        .ihit       (ihit),
        .imemload   (imemload),
        .freeze     (freeze),
        .miss       (miss),
        .correct_pc (correct_pc),
        .halt       (halt),
        .imemREN    (imemREN),
        .imemaddr   (imemaddr),
        .f_valid    (f_valid),
        .f_instr    (f_instr),
        .f_pc       (f_pc)
    );

    // fetch latch, flushed to a bubble on miss and held under freeze
    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            sb_valid <= 1'b0;
        end else if (miss) begin
            sb_valid <= 1'b0;
        end else if (!freeze) begin
            sb_valid <= f_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (!freeze) begin
            sb_instr <= f_instr;
            sb_pc    <= f_pc;
        end
    end

    // register file writes come from the retire register
    scoreboard u_scoreboard (
        .CLK        (CLK),
        .nrst       (nrst),
        .sb_valid   (sb_valid),
        .sb_instr   (sb_instr),
        .sb_pc      (sb_pc),
        .miss       (miss),
        .wb_wen     (retire_wen),
        .wb_sel     (retire_sel),
        .wb_wdat    (retire_wdat),
        .freeze     (freeze),
        .iss_valid  (iss_valid),
        .iss_op     (iss_op),
        .iss_alu_op (iss_alu_op),
        .iss_rd     (iss_rd),
        .iss_rdat1  (iss_rdat1),
        .iss_rdat2  (iss_rdat2),
        .iss_imm    (iss_imm),
        .iss_pc     (iss_pc)
    );

    execute u_execute (
        .iss_valid  (iss_valid),
        .iss_op     (iss_op),
        .iss_alu_op (iss_alu_op),
        .iss_rd     (iss_rd),
        .iss_rdat1  (iss_rdat1),
        .iss_rdat2  (iss_rdat2),
        .iss_imm    (iss_imm),
        .iss_pc     (iss_pc),
        .miss       (miss),
        .correct_pc (correct_pc),
        .ex_done    (ex_done),
        .ex_wen     (ex_wen),
        .ex_sel     (ex_sel),
        .ex_wdat    (ex_wdat),
        .ex_halt    (ex_halt)
    );

    // execute to writeback latch, the resolving branch itself still retires
    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            wb_in_done <= 1'b0;
            wb_in_wen  <= 1'b0;
            wb_in_halt <= 1'b0;
        end else begin
            wb_in_done <= ex_done;
            wb_in_wen  <= ex_wen;
            wb_in_halt <= ex_halt;
        end
    end

    always_ff @(posedge CLK) begin
        wb_in_sel  <= ex_sel;
        wb_in_wdat <= ex_wdat;
    end

    writeback u_writeback (
        .CLK     (CLK),
        .nrst    (nrst),
        .ex_done (wb_in_done),
        .ex_wen  (wb_in_wen),
        .ex_sel  (wb_in_sel),
        .ex_wdat (wb_in_wdat),
        .ex_halt (wb_in_halt),
        .wb_wen  (wb_wen),
        .wb_sel  (wb_sel),
        .wb_wdat (wb_wdat),
        .halt    (wb_halt)
    );

    // retire register, the architectural trace
    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            retire_wen <= 1'b0;
            halt       <= 1'b0;
        end else begin
            retire_wen <= wb_wen;
            halt       <= wb_halt;
        end
    end

    always_ff @(posedge CLK) begin
        retire_sel  <= wb_sel;
        retire_wdat <= wb_wdat;
    end

endmodule

// ==== src/scoreboard.sv ====
// scoreboard: decode, register file with bypass, busy bits, freeze, issue register, halt lock
`include "sc_core_cfg.svh"

module scoreboard import isa_pkg::*, datapath_pkg::*; (
    input  logic     CLK,
    input  logic     nrst,
    input  logic     sb_valid,
    input  word_t    sb_instr,
    input  pc_t      sb_pc,
    input  logic     miss,
    input  logic     wb_wen,
    input  reg_sel_t wb_sel,
    input  word_t    wb_wdat,
    output logic     freeze,
    output logic     iss_valid,
    output opcode_t  iss_op,
    output alu_op_t  iss_alu_op,
    output reg_sel_t iss_rd,
    output word_t    iss_rdat1,
    output word_t    iss_rdat2,
    output imm_t     iss_imm,
    output pc_t      iss_pc
);

    word_t             regs [`NREGS];
    logic [`NREGS-1:0] busy;
    logic [`NREGS-1:0] busy_eff;
    sb_state_t         state;

    opcode_t  d_op;
    alu_op_t  d_alu_op;
    reg_sel_t d_rd;
    reg_sel_t d_rs1;
    reg_sel_t d_rs2;
    imm_t     d_imm;
    logic     use_rs1;
    logic     use_rs2;
    logic     writes_rd;
    word_t    rdat1;
    word_t    rdat2;
    logic     hazard;
    logic     issue;
    logic     iss_writes;

    // field decode of the held instruction
    assign d_op  = opcode_t'(sb_instr[OPC_LSB +: 4]);
    assign d_rd  = sb_instr[RD_LSB +: `REG_SEL_W];
    assign d_rs1 = sb_instr[RS1_LSB +: `REG_SEL_W];
    assign d_rs2 = sb_instr[RS2_LSB +: `REG_SEL_W];
    assign d_imm = imm_t'(sb_instr[$bits(imm_t)-1:0]);

    assign use_rs1 = d_op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI, OP_BEQ};
    assign use_rs2 = d_op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_BEQ};

    // r0 is never marked busy
    assign writes_rd = (d_op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI, OP_JAL})
                       && (d_rd != '0);

    always_comb begin
        case (d_op)
            OP_SUB:  d_alu_op = ALU_SUB;
            OP_AND:  d_alu_op = ALU_AND;
            OP_OR:   d_alu_op = ALU_OR;
            OP_XOR:  d_alu_op = ALU_XOR;
            default: d_alu_op = ALU_ADD;
        endcase
    end

    // retire write this cycle already releases its register
    always_comb begin
        busy_eff = busy;
        if (wb_wen) begin
            busy_eff[wb_sel] = 1'b0;
        end
    end

    assign hazard = (use_rs1 && busy_eff[d_rs1])
                 || (use_rs2 && busy_eff[d_rs2])
                 || (writes_rd && busy_eff[d_rd]);

    // the held instruction is younger than a resolving branch, drop it on miss
    assign issue  = sb_valid && !miss && !hazard && (state == SB_RUN);
    assign freeze = sb_valid && !miss && (hazard || (state == SB_HALTED));

    // read with bypass from the retire write
    assign rdat1 = (wb_wen && (wb_sel == d_rs1)) ? wb_wdat : regs[d_rs1];
    assign rdat2 = (wb_wen && (wb_sel == d_rs2)) ? wb_wdat : regs[d_rs2];

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            for (int i = 0; i < `NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_wen) begin
            regs[wb_sel] <= wb_wdat;
        end
    end

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            busy      <= '0;
            state     <= SB_RUN;
            iss_valid <= 1'b0;
        end else begin
            busy      <= busy_eff;
            iss_valid <= issue;
            if (issue && writes_rd) begin
                busy[d_rd] <= 1'b1;
            end
            if (issue && (d_op == OP_HALT)) begin
                state <= SB_HALTED;
            end
        end
    end

    // issue register payload
    always_ff @(posedge CLK) begin
        if (issue) begin
            iss_op     <= d_op;
            iss_alu_op <= d_alu_op;
            iss_rd     <= d_rd;
            iss_rdat1  <= rdat1;
            iss_rdat2  <= rdat2;
            iss_imm    <= d_imm;
            iss_pc     <= sb_pc;
        end
    end

    // instruction in the issue register is still two edges from its write
    assign iss_writes = iss_valid
                     && (iss_op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI, OP_JAL})
                     && (iss_rd != '0);

    // a source produced by the instruction just issued is not ready yet
    a_rs1_ready: assert property (
        @(posedge CLK) disable iff (!nrst)
        issue && use_rs1 && iss_writes |-> (iss_rd != d_rs1)
    ) else $error("scoreboard: rs1 issued while busy");

    a_rs2_ready: assert property (
        @(posedge CLK) disable iff (!nrst)
        issue && use_rs2 && iss_writes |-> (iss_rd != d_rs2)
    ) else $error("scoreboard: rs2 issued while busy");

    // once halted only the halt itself may sit in the issue register
    a_halted_quiet: assert property (
        @(posedge CLK) disable iff (!nrst)
        iss_valid && (state == SB_HALTED) |-> (iss_op == OP_HALT)
    ) else $error("scoreboard: issue after halt");

endmodule

// ==== src/writeback.sv ====
// writeback stage: retire selection, r0 write suppression and sticky halt
module writeback import isa_pkg::*, datapath_pkg::*; (
    input  logic     CLK,
    input  logic     nrst,
    input  logic     ex_done,
    input  logic     ex_wen,
    input  reg_sel_t ex_sel,
    input  word_t    ex_wdat,
    input  logic     ex_halt,
    output logic     wb_wen,
    output reg_sel_t wb_sel,
    output word_t    wb_wdat,
    output logic     halt
);

    logic halt_q;
    logic halt_now;

    assign halt_now = ex_done && ex_halt;

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            halt_q <= 1'b0;
        end else if (halt_now) begin
            halt_q <= 1'b1;
        end
    end

    // r0 stays zero, nothing retires past halt
    assign wb_wen  = ex_done && ex_wen && (ex_sel != '0) && !halt_q;
    assign wb_sel  = ex_sel;
    assign wb_wdat = ex_wdat;
    assign halt    = halt_q || halt_now;

    // nothing was issued behind the halt
    a_quiet_after_halt: assert property (
        @(posedge CLK) disable iff (!nrst)
        halt_q |-> !ex_done
    ) else $error("writeback: instruction arrived after halt");

endmodule
